// File: verilog/tea_pkg.sv
/* TEA package
   word types, register map, round constant and the control/status word */
`default_nettype none

package tea_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] step_t;

	localparam word_t TEA_DELTA = 32'h9E3779B9;
	localparam int STEPS_PER_ROUND = 9;

	// wishbone word address map
	localparam int ADR_W = 3;

	localparam logic [ADR_W-1:0] ADR_KEY0 = 3'd0;
	localparam logic [ADR_W-1:0] ADR_KEY1 = 3'd1;
	localparam logic [ADR_W-1:0] ADR_KEY2 = 3'd2;
	localparam logic [ADR_W-1:0] ADR_KEY3 = 3'd3;
	localparam logic [ADR_W-1:0] ADR_V0 = 3'd4;
	localparam logic [ADR_W-1:0] ADR_V1 = 3'd5;
	localparam logic [ADR_W-1:0] ADR_CSR = 3'd6;

	// written by the host
	typedef struct packed {
		logic [30:0] rsvd;
		logic start;
	} csr_ctrl_t;

	// read back by the host
	typedef struct packed {
		logic [29:0] zero;
		logic done;
		logic busy;
	} csr_status_t;

	typedef union packed {
		csr_ctrl_t ctrl;
		csr_status_t status;
	} ctrl_status_u;

endpackage

`default_nettype wire

// File: verilog/tea_operand_if.sv
/* TEA operand bundle
   key and plaintext words from the register block to the datapath */
`default_nettype none

interface tea_operand_if;
	import tea_pkg::*;

	word_t key0;
	word_t key1;
	word_t key2;
	word_t key3;
	word_t pt0;
	word_t pt1;

	// register block owns the words
	modport regs (
		output key0, key1, key2, key3, pt0, pt1
	);

	modport core (
		input key0, key1, key2, key3, pt0, pt1
	);

endinterface

`default_nettype wire

// File: verilog/tea_wb_regs.sv
/* TEA wishbone register block
   key and plaintext registers, start control and status read-back */
`default_nettype none

module tea_wb_regs (
	input wire clk,
	input wire rst_n,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [tea_pkg::ADR_W-1:0] wb_adr,
	input wire tea_pkg::word_t wb_dat_w,
	output tea_pkg::word_t wb_dat_r,
	output logic wb_ack,
	tea_operand_if.regs operand,
	output logic start,
	input wire busy,
	input wire done,
	input wire tea_pkg::word_t res_v0,
	input wire tea_pkg::word_t res_v1
);
	import tea_pkg::*;

	logic req;
	logic wr_ok;
	ctrl_status_u csr_wr;
	ctrl_status_u csr_rd;

	// a new access only while no ack is out
	assign req = wb_cyc & wb_stb & ~wb_ack;
	assign wr_ok = req & wb_we & ~busy;
	assign csr_wr = wb_dat_w;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wb_ack <= 1'b0;
			start <= 1'b0;
		end
		else
		begin
			wb_ack <= req;
			// pulse lines up with the ack of the start write
			start <= wr_ok & (wb_adr == ADR_CSR) & csr_wr.ctrl.start;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			operand.key0 <= '0;
			operand.key1 <= '0;
			operand.key2 <= '0;
			operand.key3 <= '0;
			operand.pt0 <= '0;
			operand.pt1 <= '0;
		end
		else if (wr_ok)
		begin
			case (wb_adr)
				ADR_KEY0: operand.key0 <= wb_dat_w;
				ADR_KEY1: operand.key1 <= wb_dat_w;
				ADR_KEY2: operand.key2 <= wb_dat_w;
				ADR_KEY3: operand.key3 <= wb_dat_w;
				ADR_V0: operand.pt0 <= wb_dat_w;
				ADR_V1: operand.pt1 <= wb_dat_w;
				default: ;
			endcase
		end
	end

	always_comb
	begin
		csr_rd = '0;
		csr_rd.status.busy = busy;
		csr_rd.status.done = done;
	end

	// read word follows the held address, sampled during ack
	always_comb
	begin
		case (wb_adr)
			ADR_KEY0: wb_dat_r = operand.key0;
			ADR_KEY1: wb_dat_r = operand.key1;
			ADR_KEY2: wb_dat_r = operand.key2;
			ADR_KEY3: wb_dat_r = operand.key3;
			ADR_V0: wb_dat_r = res_v0;
			ADR_V1: wb_dat_r = res_v1;
			ADR_CSR: wb_dat_r = csr_rd;
			default: wb_dat_r = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/tea_sequencer.sv
/* TEA step sequencer
   counts datapath steps and rounds, flags busy and done */
`default_nettype none

module tea_sequencer #(
	parameter int ROUNDS = 32
) (
	input wire clk,
	input wire rst_n,
	input wire start,
	output logic load,
	output logic active,
	output tea_pkg::step_t step,
	output logic busy,
	output logic done
);
	import tea_pkg::*;

	localparam int RND_W = (ROUNDS > 1) ? $clog2(ROUNDS) : 1;
	localparam step_t LAST_STEP = step_t'(STEPS_PER_ROUND - 1);

	logic [RND_W-1:0] round;
	logic last_round;

	assign last_round = (round == RND_W'(ROUNDS - 1));
	assign load = start;
	assign active = busy;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			step <= '0;
			round <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end
		else if (start)
		begin
			step <= '0;
			round <= '0;
			busy <= 1'b1;
			done <= 1'b0;
		end
		else if (busy)
		begin
			if (step == LAST_STEP)
			begin
				step <= '0;
				// done rises as busy falls
				if (last_round)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
				else
				begin
					round <= round + 1'b1;
				end
			end
			else
			begin
				step <= step + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/tea_datapath.sv
/* TEA datapath
   block halves, sum and a temporary around one shared add and xor */
`default_nettype none

module tea_datapath (
	input wire clk,
	input wire rst_n,
	tea_operand_if.core operand,
	input wire load,
	input wire active,
	input wire tea_pkg::step_t step,
	output tea_pkg::word_t v0,
	output tea_pkg::word_t v1
);
	import tea_pkg::*;

	word_t sum;
	word_t tmp;
	word_t add_a;
	word_t add_b;
	word_t xor_t;
	word_t unit_out;

	// step picks the adder operands and the xor term
	always_comb
	begin
		add_a = sum;
		add_b = TEA_DELTA;
		xor_t = '0;
		case (step)
			4'd1:
			begin
				add_a = v1 << 4;
				add_b = operand.key0;
			end
			4'd2:
			begin
				add_a = v1;
				add_b = sum;
				xor_t = tmp;
			end
			4'd3:
			begin
				add_a = v1 >> 5;
				add_b = operand.key1;
				xor_t = tmp;
			end
			4'd4:
			begin
				add_a = v0;
				add_b = tmp;
			end
			4'd5:
			begin
				add_a = v0 << 4;
				add_b = operand.key2;
			end
			4'd6:
			begin
				add_a = v0;
				add_b = sum;
				xor_t = tmp;
			end
			4'd7:
			begin
				add_a = v0 >> 5;
				add_b = operand.key3;
				xor_t = tmp;
			end
			4'd8:
			begin
				add_a = v1;
				add_b = tmp;
			end
			default:
			begin
				// step 0, sum plus delta
				add_a = sum;
				add_b = TEA_DELTA;
			end
		endcase
	end

	assign unit_out = (add_a + add_b) ^ xor_t;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			v0 <= '0;
			v1 <= '0;
			sum <= '0;
			tmp <= '0;
		end
		else if (load)
		begin
			v0 <= operand.pt0;
			v1 <= operand.pt1;
			sum <= '0;
			tmp <= '0;
		end
		else if (active)
		begin
			case (step)
				4'd0: sum <= unit_out;
				4'd4: v0 <= unit_out;
				4'd8: v1 <= unit_out;
				default: tmp <= unit_out;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/tea_top.sv
/* TEA encryptor
   wishbone classic slave around a step-serial TEA core */
`default_nettype none

module tea_top #(
	parameter int ROUNDS = 32
) (
	input wire clk,
	input wire rst_n,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [tea_pkg::ADR_W-1:0] wb_adr,
	input wire tea_pkg::word_t wb_dat_w,
	output tea_pkg::word_t wb_dat_r,
	output logic wb_ack
);
	import tea_pkg::*;

	logic start;
	logic load;
	logic active;
	logic busy;
	logic done;
	step_t step;
	word_t res_v0;
	word_t res_v1;

	tea_operand_if operand ();

	tea_wb_regs u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.operand(operand.regs),
		.start(start),
		.busy(busy),
		.done(done),
		.res_v0(res_v0),
		.res_v1(res_v1)
	);

	tea_sequencer #(
		.ROUNDS(ROUNDS)
	) u_seq (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.load(load),
		.active(active),
		.step(step),
		.busy(busy),
		.done(done)
	);

	tea_datapath u_core (
		.clk(clk),
		.rst_n(rst_n),
		.operand(operand.core),
		.load(load),
		.active(active),
		.step(step),
		.v0(res_v0),
		.v1(res_v1)
	);

endmodule

`default_nettype wire

// File: tb/tea_tb.sv
/* TEA encryptor testbench
   directed Wishbone tests against a TEA reference model */
`default_nettype none

module tea_tb;
	import tea_pkg::*;

	localparam int ROUNDS = 32;
	localparam int RUN_CYCLES = 9 * ROUNDS;
	localparam int TIMEOUT_CYCLES = 6 * 40 * (RUN_CYCLES + 40);
	localparam word_t DELTA = 32'h9E3779B9;

	logic clk;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [ADR_W-1:0] wb_adr;
	word_t wb_dat_w;
	word_t wb_dat_r;
	logic wb_ack;

	int cycle = 0;
	int errors = 0;
	int tests_failed = 0;
	int begin_cyc;
	int ack_cyc;

	tea_top #(
		.ROUNDS(ROUNDS)
	) UUT (
		.clk(clk),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES)
		begin
			$display("timeout: tests still running after %0d cycles", cycle);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// one classic cycle with the ack one edge after the request
	task automatic wb_access(input logic we, input logic [ADR_W-1:0] adr, input word_t wdata,
		output word_t rdata);
		int waited;
		@(posedge clk);
		#1;
		begin_cyc = cycle;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		@(posedge clk);
		#1;
		waited = 1;
		while (!wb_ack && waited < 8)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		ack_cyc = cycle;
		rdata = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		if (!wb_ack)
		begin
			$display("bus access to address %0d was never acknowledged", adr);
			errors++;
		end
		else if (waited != 1)
		begin
			$display("ERROR t=%0t ack for address %0d after %0d cycles, expected 1",
				$time, adr, waited);
			errors++;
		end
	endtask

	task automatic wb_write(input logic [ADR_W-1:0] adr, input word_t data);
		word_t unused;
		wb_access(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input logic [ADR_W-1:0] adr, output word_t data);
		wb_access(1'b0, adr, '0, data);
	endtask

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("ERROR t=%0t %s: read %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_status(input string what, input ctrl_status_u got,
		input ctrl_status_u exp);
		if (got !== exp)
		begin
			$display("ERROR t=%0t %s: busy %b done %b (word %h), expected busy %b done %b",
				$time, what, got.status.busy, got.status.done, got, exp.status.busy,
				exp.status.done);
			errors++;
		end
	endtask

	function automatic ctrl_status_u status_of(input logic busy, input logic done);
		ctrl_status_u s;
		s = '0;
		s.status.busy = busy;
		s.status.done = done;
		return s;
	endfunction

	// straight TEA encryption
	task automatic tea_model(input word_t key [4], input word_t p0, input word_t p1,
		output word_t c0, output word_t c1);
		word_t sum;
		sum = '0;
		c0 = p0;
		c1 = p1;
		for (int i = 0; i < ROUNDS; i++)
		begin
			sum = sum + DELTA;
			c0 = c0 + (((c1 << 4) + key[0]) ^ (c1 + sum) ^ ((c1 >> 5) + key[1]));
			c1 = c1 + (((c0 << 4) + key[2]) ^ (c0 + sum) ^ ((c0 >> 5) + key[3]));
		end
	endtask

	task automatic load_operands(input word_t key [4], input word_t p0, input word_t p1);
		for (int i = 0; i < 4; i++)
			wb_write(ADR_W'(i), key[i]);
		wb_write(ADR_V0, p0);
		wb_write(ADR_V1, p1);
	endtask

	task automatic start_encryption;
		ctrl_status_u c;
		c = '0;
		c.ctrl.start = 1'b1;
		wb_write(ADR_CSR, c);
	endtask

	task automatic wait_done;
		word_t w;
		ctrl_status_u st;
		int polls;
		polls = 0;
		st = '0;
		while (!st.status.done && polls < RUN_CYCLES)
		begin
			wb_read(ADR_CSR, w);
			st = w;
			polls++;
		end
		if (!st.status.done)
		begin
			$display("done flag never set after %0d status reads", polls);
			errors++;
		end
	endtask

	task automatic check_result(input string what, input word_t key [4], input word_t p0,
		input word_t p1);
		word_t c0;
		word_t c1;
		word_t e0;
		word_t e1;
		tea_model(key, p0, p1, e0, e1);
		wb_read(ADR_V0, c0);
		wb_read(ADR_V1, c1);
		check_word({what, " v0"}, c0, e0);
		check_word({what, " v1"}, c1, e1);
	endtask

	task automatic random_operands(output word_t key [4], output word_t p0, output word_t p1);
		for (int i = 0; i < 4; i++)
			key[i] = $urandom();
		p0 = $urandom();
		p1 = $urandom();
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before)
			$display("test %s: ok", name);
		else
		begin
			$display("test %s: %0d errors", name, errors - err_before);
			tests_failed++;
		end
	endtask

	task automatic test_reset_state;
		word_t w;
		wb_read(ADR_CSR, w);
		check_status("status after reset", w, status_of(1'b0, 1'b0));
		for (int i = 0; i < 4; i++)
		begin
			wb_read(ADR_W'(i), w);
			check_word("key after reset", w, '0);
		end
		wb_read(3'd7, w);
		check_word("unused address 7", w, '0);
	endtask

	task automatic test_known_vector;
		word_t key [4];
		word_t w;
		key = '{default: '0};
		load_operands(key, '0, '0);
		start_encryption();
		wait_done();
		wb_read(ADR_V0, w);
		check_word("zero vector v0", w, 32'h41EA3A0A);
		wb_read(ADR_V1, w);
		check_word("zero vector v1", w, 32'h94BAA940);
		wb_read(ADR_CSR, w);
		check_status("status after zero vector", w, status_of(1'b0, 1'b1));
	endtask

	task automatic test_random_blocks;
		word_t key [4];
		word_t p0;
		word_t p1;
		for (int n = 0; n < 30; n++)
		begin
			random_operands(key, p0, p1);
			load_operands(key, p0, p1);
			start_encryption();
			wait_done();
			check_result("random block", key, p0, p1);
		end
	endtask

	task automatic test_busy_writes;
		word_t key [4];
		word_t other [4];
		word_t p0;
		word_t p1;
		word_t q0;
		word_t q1;
		word_t w;
		int first_ack;
		random_operands(key, p0, p1);
		random_operands(other, q0, q1);
		load_operands(key, p0, p1);
		start_encryption();
		first_ack = ack_cyc;
		// all of these land while the core runs
		load_operands(other, q0, q1);
		start_encryption();
		wait_done();
		// a restart from the second start would push done out
		if (begin_cyc - first_ack > RUN_CYCLES + 1)
		begin
			$display("ERROR t=%0t done %0d cycles after first start, expected at most %0d",
				$time, begin_cyc - first_ack, RUN_CYCLES + 1);
			errors++;
		end
		check_result("busy writes", key, p0, p1);
		for (int i = 0; i < 4; i++)
		begin
			wb_read(ADR_W'(i), w);
			check_word("key kept while busy", w, key[i]);
		end
		// plaintext registers still hold the first block
		start_encryption();
		wait_done();
		check_result("rerun after busy writes", key, p0, p1);
	endtask

	task automatic test_busy_length;
		word_t key [4];
		word_t p0;
		word_t p1;
		word_t w;
		int start_ack;
		int offset;
		random_operands(key, p0, p1);
		load_operands(key, p0, p1);
		start_encryption();
		start_ack = ack_cyc;
		offset = 0;
		while (offset < RUN_CYCLES)
		begin
			wb_read(ADR_CSR, w);
			offset = begin_cyc - start_ack;
			if (offset <= RUN_CYCLES - 2)
				check_status("status while running", w, status_of(1'b1, 1'b0));
			else if (offset >= RUN_CYCLES)
				check_status("status after last step", w, status_of(1'b0, 1'b1));
		end
		check_result("busy length", key, p0, p1);
	endtask

	task automatic test_restart;
		word_t key [4];
		word_t p0;
		word_t p1;
		word_t w;
		random_operands(key, p0, p1);
		load_operands(key, p0, p1);
		start_encryption();
		wb_read(ADR_CSR, w);
		check_status("status after restart", w, status_of(1'b1, 1'b0));
		wait_done();
		check_result("restart", key, p0, p1);
	endtask

	initial
	begin
		int err_before;
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		void'($urandom(41));
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		err_before = errors;
		test_reset_state();
		report_test("reset_state", err_before);
		err_before = errors;
		test_known_vector();
		report_test("known_vector", err_before);
		err_before = errors;
		test_random_blocks();
		report_test("random_blocks", err_before);
		err_before = errors;
		test_busy_writes();
		report_test("busy_writes", err_before);
		err_before = errors;
		test_busy_length();
		report_test("busy_length", err_before);
		err_before = errors;
		test_restart();
		report_test("restart", err_before);

		$display("6 tests, %0d failed, %0d errors", tests_failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
verilog/tea_pkg.sv
verilog/tea_operand_if.sv
verilog/tea_wb_regs.sv
verilog/tea_sequencer.sv
verilog/tea_datapath.sv
verilog/tea_top.sv
tb/tea_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the TEA testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 -Wno-fatal --top-module tea_tb -f all.f -o tea_sim

./obj_dir/tea_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi

if ! grep -q "RESULT: PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0
